//--- cache_pkg.sv
package cache_pkg;

    localparam int addr_w   = 16;
    localparam int data_w   = 32;
    localparam int tag_w    = 11;
    localparam int index_w  = 3;
    localparam int offset_w = 2;

    localparam int num_sets  = 8;
    localparam int num_ways  = 8;
    localparam int way_w     = 3;
    localparam int tree_bits = 7; // num_ways - 1 decision nodes

    // controller state codes
    localparam int state_w = 3;
    localparam logic [state_w-1:0] st_idle        = 3'd0;
    localparam logic [state_w-1:0] st_lookup      = 3'd1;
    localparam logic [state_w-1:0] st_mem_wait    = 3'd2;
    localparam logic [state_w-1:0] st_mem_release = 3'd3;
    localparam logic [state_w-1:0] st_respond     = 3'd4;
    localparam logic [state_w-1:0] st_release     = 3'd5;

    typedef logic [way_w-1:0] way_t;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset; // byte offset, unused
    } addr_s;

    // same address seen as a bus word or as its fields
    typedef union packed {
        logic [addr_w-1:0] word;
        addr_s             f;
    } addr_u;

endpackage : cache_pkg

//--- lookup_if.sv
`timescale 1ns/1ns

interface lookup_if import cache_pkg::*; ();

    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    way_t               way;
    logic               hit;
    way_t               hit_way; // valid only while hit is high
    logic               fill;
    logic               write;   // write hit, data array only
    logic [data_w-1:0]  wdata;
    logic [data_w-1:0]  rdata;

    modport ctrl (
        output index, tag, way, fill, write, wdata,
        input  hit, hit_way, rdata
    );

    modport tags (
        input  index, tag, way, fill,
        output hit, hit_way
    );

    modport data (
        input  index, way, fill, write, wdata,
        output rdata
    );

endinterface : lookup_if

//--- plru_tree.sv
`timescale 1ns/1ns

module plru_tree import cache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               touch,
    input  logic [index_w-1:0] touch_index,
    input  way_t               touch_way,
    input  logic [index_w-1:0] victim_index,
    output way_t               victim
);

    // node 0 is the root, 1..2 the middle level, 3..6 the leaf pairs
    logic [tree_bits-1:0] tree [num_sets];
    logic [tree_bits-1:0] next_bits;
    way_t                 touch_mid;
    way_t                 touch_leaf;
    logic [tree_bits-1:0] vic_bits;
    way_t                 vic_mid;
    way_t                 vic_leaf;

    // nodes on the path of the touched way
    assign touch_mid  = way_t'(1) + {2'b00, touch_way[2]};
    assign touch_leaf = way_t'(3) + {1'b0, touch_way[2:1]};

    // every node on the path points away from the touched way
    always_comb begin
        next_bits             = tree[touch_index];
        next_bits[0]          = ~touch_way[2];
        next_bits[touch_mid]  = ~touch_way[1];
        next_bits[touch_leaf] = ~touch_way[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[touch_index] <= next_bits;
        end
    end

    // walk from the root, 0 = lower half, 1 = upper half
    assign vic_bits = tree[victim_index];
    assign vic_mid  = way_t'(1) + {2'b00, vic_bits[0]};
    assign vic_leaf = way_t'(3) + {1'b0, vic_bits[0], vic_bits[vic_mid]};
    assign victim   = {vic_bits[0], vic_bits[vic_mid], vic_bits[vic_leaf]};

endmodule : plru_tree

//--- tag_store.sv
`timescale 1ns/1ns

module tag_store import cache_pkg::*; (
    input logic    clk,
    input logic    rst,
    lookup_if.tags lk
);

    logic [num_ways-1:0] valid [num_sets];
    logic [tag_w-1:0]    tags  [num_sets][num_ways];
    logic [num_ways-1:0] match; // one bit per way of the indexed set

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
            end
        end else if (lk.fill) begin
            valid[lk.index][lk.way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill) begin
            tags[lk.index][lk.way] <= lk.tag;
        end
    end

    // compare against all ways of the set at once
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid[lk.index][w] && (tags[lk.index][w] == lk.tag);
        end
    end

    assign lk.hit = |match;

    // a tag sits in at most one way, so a plain encoder is enough
    always_comb begin
        lk.hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (match[w]) begin
                lk.hit_way = way_t'(w);
            end
        end
    end

endmodule : tag_store

//--- line_store.sv
`timescale 1ns/1ns

module line_store import cache_pkg::*; (
    input logic    clk,
    lookup_if.data lk
);

    logic [data_w-1:0] words [num_sets][num_ways];

    always_ff @(posedge clk) begin
        if (lk.fill || lk.write) begin
            words[lk.index][lk.way] <= lk.wdata;
        end
    end

    assign lk.rdata = words[lk.index][lk.way]; // async read of the selected way

endmodule : line_store

//--- cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl import cache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req,
    input  logic               cpu_we,
    input  logic [addr_w-1:0]  cpu_addr,
    input  logic [data_w-1:0]  cpu_wdata,
    output logic               cpu_ack,
    output logic [data_w-1:0]  cpu_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output logic [addr_w-1:0]  mem_addr,
    output logic [data_w-1:0]  mem_wdata,
    input  logic               mem_ack,
    input  logic [data_w-1:0]  mem_rdata,
    lookup_if.ctrl             lk,
    output logic               touch,
    output logic [index_w-1:0] touch_index,
    output way_t               touch_way,
    input  way_t               victim
);

    logic [state_w-1:0] state;
    logic [state_w-1:0] state_next;
    addr_u              req_addr;
    logic               req_we;
    logic [data_w-1:0]  req_wdata;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (cpu_req) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                // writes always go through to memory
                if (req_we || !lk.hit) begin
                    state_next = st_mem_wait;
                end else begin
                    state_next = st_respond;
                end
            end
            st_mem_wait: begin
                if (mem_ack) begin
                    state_next = st_mem_release;
                end
            end
            st_mem_release: begin
                if (!mem_ack) begin
                    state_next = st_respond;
                end
            end
            st_respond: begin
                state_next = st_release;
            end
            st_release: begin
                if (!cpu_req) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cpu_req) begin
            req_addr.word <= cpu_addr;
            req_we        <= cpu_we;
            req_wdata     <= cpu_wdata;
        end
        if (state == st_lookup && lk.hit) begin
            cpu_rdata <= lk.rdata;
        end
        if (lk.fill) begin
            cpu_rdata <= mem_rdata; // miss data goes straight back to the cpu
        end
    end

    assign lk.index = req_addr.f.index;
    assign lk.tag   = req_addr.f.tag;
    assign lk.way   = lk.hit ? lk.hit_way : victim;
    assign lk.fill  = (state == st_mem_wait) && mem_ack && !req_we;
    assign lk.write = (state == st_lookup) && req_we && lk.hit; // no allocate on miss
    assign lk.wdata = lk.fill ? mem_rdata : req_wdata;

    assign touch       = ((state == st_lookup) && lk.hit) || lk.fill;
    assign touch_index = req_addr.f.index;
    assign touch_way   = lk.way;

    assign cpu_ack   = (state == st_release);
    assign mem_req   = (state == st_mem_wait);
    assign mem_we    = req_we;
    assign mem_addr  = req_addr.word;
    assign mem_wdata = req_wdata;

endmodule : cache_ctrl

//--- cache_top.sv
`timescale 1ns/1ns

module cache_top import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [data_w-1:0] cpu_wdata,
    output logic              cpu_ack,
    output logic [data_w-1:0] cpu_rdata,
    output logic              mem_req,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    input  logic              mem_ack,
    input  logic [data_w-1:0] mem_rdata
);

    logic               touch;
    logic [index_w-1:0] touch_index;
    way_t               touch_way;
    way_t               victim;

    lookup_if lk ();

    cache_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_ack     (cpu_ack),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .lk          (lk.ctrl),
        .touch       (touch),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .victim      (victim)
    );

    tag_store tags_i (
        .clk (clk),
        .rst (rst),
        .lk  (lk.tags)
    );

    line_store data_i (
        .clk (clk),
        .lk  (lk.data)
    );

    plru_tree plru_i (
        .clk          (clk),
        .rst          (rst),
        .touch        (touch),
        .touch_index  (touch_index),
        .touch_way    (touch_way),
        .victim_index (lk.index), // victim of the set under lookup
        .victim       (victim)
    );

endmodule : cache_top

//--- cache_properties.sv
`timescale 1ns/1ns

module cache_properties (
    input logic clk,
    input logic rst,
    input logic cpu_req,
    input logic cpu_ack,
    input logic mem_req,
    input logic mem_ack
);

    int failures = 0;

    // requester holds req until the responder acks
    assert property (@(posedge clk) disable iff (rst) $fell(cpu_req) |-> cpu_ack)
        else begin
            $error("cpu_req dropped before cpu_ack");
            failures++;
        end
    assert property (@(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req)
        else begin
            $error("mem_req dropped before mem_ack");
            failures++;
        end

    // cpu_ack is registered, so it answers the req of the previous sample
    assert property (@(posedge clk) disable iff (rst) $rose(cpu_ack) |-> $past(cpu_req))
        else begin
            $error("cpu_ack rose without cpu_req");
            failures++;
        end
    assert property (@(posedge clk) disable iff (rst) $rose(mem_ack) |-> mem_req)
        else begin
            $error("mem_ack rose without mem_req");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst) $fell(cpu_ack) |-> !cpu_req)
        else begin
            $error("cpu_ack fell while cpu_req was still high");
            failures++;
        end
    assert property (@(posedge clk) disable iff (rst) $fell(mem_ack) |-> !mem_req)
        else begin
            $error("mem_ack fell while mem_req was still high");
            failures++;
        end

endmodule : cache_properties

bind cache_ctrl cache_properties props_i (.*);

//--- cache_checker.sv
`timescale 1ns/1ns

module cache_checker import cache_pkg::*; (
    input  logic              clk, rst, cpu_req, cpu_we, cpu_ack, mem_req, mem_we, exp_hit,
    input  logic [addr_w-1:0] cpu_addr, mem_addr,
    input  logic [data_w-1:0] cpu_wdata, cpu_rdata, mem_wdata,
    input  logic [8*16-1:0]   test_name,
    output int                errors, done
);

    localparam int word_count = 2 ** (addr_w - offset_w);

    logic [data_w-1:0]    mirror [word_count]; // memory as the cpu has written it
    logic                 valid  [num_sets][num_ways];
    logic [tag_w-1:0]     tags   [num_sets][num_ways];
    logic [tree_bits-1:0] tree   [num_sets];
    addr_u                cur;
    logic [data_w-1:0]    cur_wdata;
    logic                 cur_we, model_hit, active, acked, mem_req_q;
    int                   mem_count;

    function automatic logic [data_w-1:0] initial_word(input logic [addr_w-offset_w-1:0] w);
        return {w, 2'b01, ~w, 2'b10};
    endfunction

    // heap order, children of node n are 2n+1 (lower half) and 2n+2 (upper half)
    function automatic way_t lru_victim(input logic [tree_bits-1:0] t);
        int   node;
        way_t way;
        node = 0;
        way  = '0;
        for (int lvl = 0; lvl < way_w; lvl++) begin
            way  = {way[way_w-2:0], t[node]};
            node = 2 * node + 1 + t[node];
        end
        return way;
    endfunction

    function automatic logic [tree_bits-1:0] touched(input logic [tree_bits-1:0] t, input way_t way);
        logic [tree_bits-1:0] r;
        int                   node;
        r    = t;
        node = 0;
        for (int lvl = way_w - 1; lvl >= 0; lvl--) begin
            r[node] = !way[lvl]; // point at the other half
            node    = 2 * node + 1 + way[lvl];
        end
        return r;
    endfunction

    task automatic report(input string what, input logic [data_w-1:0] expected, actual);
        $display("error %0s %0s expected %0h actual %0h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic start_request();
        logic [index_w-1:0] idx;
        way_t               way;
        logic               hit;
        idx = cur.f.index;
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid[idx][w] && tags[idx][w] == cur.f.tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit && !cur_we) begin // read miss fills the victim
            way            = lru_victim(tree[idx]);
            valid[idx][way] = 1'b1;
            tags[idx][way]  = cur.f.tag;
        end
        if (hit || !cur_we) begin
            tree[idx] = touched(tree[idx], way);
        end
        if (cur_we) begin
            mirror[cur.word[addr_w-1:offset_w]] = cur_wdata;
        end
        model_hit = hit;
    endtask

    task automatic check_response();
        int expected_mem;
        expected_mem = (cur_we || !model_hit) ? 1 : 0; // writes always go to memory
        if (mem_count != expected_mem) begin
            report("mem_transactions", expected_mem, mem_count);
        end
        if (!cur_we) begin
            if ((mem_count == 0) != exp_hit) begin
                report("hit", exp_hit, mem_count == 0);
            end
            if (cpu_rdata !== mirror[cur.word[addr_w-1:offset_w]]) begin
                report("rdata", mirror[cur.word[addr_w-1:offset_w]], cpu_rdata);
            end
        end
    endtask

    initial begin
        for (int a = 0; a < word_count; a++) begin
            mirror[a] = initial_word(a[addr_w-offset_w-1:0]);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] = '0;
                for (int w = 0; w < num_ways; w++) begin
                    valid[s][w] = 1'b0;
                end
            end
            active    = 1'b0;
            acked     = 1'b0;
            mem_req_q = 1'b0;
            errors    = 0;
            done      = 0;
        end else begin
            if (cpu_req && !active) begin
                cur.word  = cpu_addr;
                cur_we    = cpu_we;
                cur_wdata = cpu_wdata;
                mem_count = 0;
                active    = 1'b1;
                acked     = 1'b0;
                start_request();
            end
            if (mem_req && !mem_req_q) begin
                mem_count++;
                if (!active) begin
                    $display("memory request seen with no CPU request open");
                    errors++;
                end
                if (mem_we !== cur_we) begin
                    report("mem_we", cur_we, mem_we);
                end
                if (mem_addr !== cur.word) begin
                    report("mem_addr", cur.word, mem_addr);
                end
                if (cur_we && mem_wdata !== cur_wdata) begin
                    report("mem_wdata", cur_wdata, mem_wdata);
                end
            end
            if (cpu_ack && active && !acked) begin
                acked = 1'b1;
                done++;
                check_response();
            end
            if (!cpu_req && !cpu_ack) begin
                active = 1'b0;
            end
            mem_req_q = mem_req;
        end
    end

endmodule : cache_checker

//--- tb_cache.sv
`timescale 1ns/1ns

module tb_cache import cache_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int mem_latency  = 3;  // negedges from mem_req to mem_ack
    localparam int max_tests    = 32;
    localparam int test_cycles  = 30; // upper bound for one request
    localparam int word_count   = 2 ** (addr_w - offset_w);

    logic              clk, rst, cpu_req, cpu_we, cpu_ack, mem_req, mem_we, mem_ack, exp_hit;
    logic [addr_w-1:0] cpu_addr, mem_addr;
    logic [data_w-1:0] cpu_wdata, cpu_rdata, mem_wdata, mem_rdata;
    logic [8*16-1:0]   test_name;
    int                errors, done, n_tests, run_errors, assert_errors;

    logic [8*16-1:0]   name_tab  [max_tests];
    logic              we_tab    [max_tests];
    logic              hit_tab   [max_tests];
    logic [addr_w-1:0] addr_tab  [max_tests];
    logic [data_w-1:0] wdata_tab [max_tests];
    logic [data_w-1:0] mem_words [word_count];

    cache_top cache_top_i (.*);
    cache_checker check_i (.*);

    // every bit of the word address shows up in the stored word
    function automatic logic [data_w-1:0] initial_word(input logic [addr_w-offset_w-1:0] w);
        return {w, 2'b01, ~w, 2'b10};
    endfunction

    task automatic add_op(input logic [8*16-1:0] name, input logic we, input logic hit,
                          input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
        name_tab[n_tests]  = name;
        we_tab[n_tests]    = we;
        hit_tab[n_tests]   = hit;
        addr_tab[n_tests]  = addr;
        wdata_tab[n_tests] = wdata;
        n_tests++;
    endtask

    // name, write, expected hit, address, write data
    task automatic build_table();
        add_op("cold_rd",         1'b0, 1'b0, 16'h0020, '0);
        add_op("repeat_rd",       1'b0, 1'b1, 16'h0020, '0);
        add_op("offset_rd",       1'b0, 1'b1, 16'h0023, '0);
        add_op("fill_w0",         1'b0, 1'b0, 16'h002c, '0); // set 3, tags 1 to 8
        add_op("fill_w4",         1'b0, 1'b0, 16'h004c, '0);
        add_op("fill_w2",         1'b0, 1'b0, 16'h006c, '0);
        add_op("fill_w6",         1'b0, 1'b0, 16'h008c, '0);
        add_op("set1_cold",       1'b0, 1'b0, 16'h0044, '0);
        add_op("fill_w1",         1'b0, 1'b0, 16'h00ac, '0);
        add_op("fill_w5",         1'b0, 1'b0, 16'h00cc, '0);
        add_op("fill_w3",         1'b0, 1'b0, 16'h00ec, '0);
        add_op("fill_w7",         1'b0, 1'b0, 16'h010c, '0);
        add_op("set1_hit",        1'b0, 1'b1, 16'h0044, '0);
        add_op("touch_w0",        1'b0, 1'b1, 16'h002c, '0);
        add_op("evict_t2",        1'b0, 1'b0, 16'h012c, '0); // tree now names way 4
        add_op("keep_t1",         1'b0, 1'b1, 16'h002c, '0);
        add_op("keep_t3",         1'b0, 1'b1, 16'h006c, '0);
        add_op("keep_t9",         1'b0, 1'b1, 16'h012c, '0);
        add_op("refetch_t2",      1'b0, 1'b0, 16'h004c, '0);
        add_op("set0_hit",        1'b0, 1'b1, 16'h0020, '0);
        add_op("wr_hit",          1'b1, 1'b1, 16'h0020, 32'hdeadbeef);
        add_op("rd_after_wr",     1'b0, 1'b1, 16'h0020, '0);
        add_op("wr_miss",         1'b1, 1'b0, 16'hfff4, 32'h12345678);
        add_op("rd_after_wrmiss", 1'b0, 1'b0, 16'hfff4, '0);
        add_op("rd_again",        1'b0, 1'b1, 16'hfff4, '0);
        add_op("set1_still",      1'b0, 1'b1, 16'h0044, '0);
    endtask

    task automatic run_op(input int i);
        @(negedge clk);
        test_name = name_tab[i];
        exp_hit   = hit_tab[i];
        cpu_we    = we_tab[i];
        cpu_addr  = addr_tab[i];
        cpu_wdata = wdata_tab[i];
        cpu_req   = 1'b1;
        do begin
            @(negedge clk);
        end while (!cpu_ack);
        repeat (i % 3) @(negedge clk); // a slow cpu keeps req up after the ack
        cpu_req = 1'b0;
        do begin
            @(negedge clk);
        end while (cpu_ack);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // four-phase memory with a fixed response delay
    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int a = 0; a < word_count; a++) begin
            mem_words[a] = initial_word(a[addr_w-offset_w-1:0]);
        end
        forever begin
            @(negedge clk);
            if (mem_req) begin
                repeat (mem_latency - 1) @(negedge clk);
                if (mem_we) begin
                    mem_words[mem_addr[addr_w-1:offset_w]] = mem_wdata;
                end else begin
                    mem_rdata = mem_words[mem_addr[addr_w-1:offset_w]];
                end
                mem_ack = 1'b1;
                do begin
                    @(negedge clk);
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        rst           = 1'b1;
        cpu_req       = 1'b0;
        cpu_we        = 1'b0;
        cpu_addr      = '0;
        cpu_wdata     = '0;
        test_name     = '0;
        exp_hit       = 1'b0;
        n_tests       = 0;
        run_errors    = 0;
        assert_errors = 0;
        build_table();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_op(i);
        end
        @(negedge clk);
        assert_errors = cache_top_i.ctrl_i.props_i.failures;
        if (done != n_tests) begin
            $display("only %0d of %0d requests reached the checker", done, n_tests);
            run_errors++;
        end
        $display("requests %0d, checker errors %0d, assertion errors %0d, run errors %0d",
                 done, errors, assert_errors, run_errors);
        if (errors == 0 && run_errors == 0 && assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        @(negedge rst);
        repeat (n_tests * test_cycles) @(posedge clk);
        $display("timeout after %0d cycles, a handshake never completed", n_tests * test_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_cache

//--- build.f
cache_pkg.sv
lookup_if.sv
plru_tree.sv
tag_store.sv
line_store.sv
cache_ctrl.sv
cache_top.sv
cache_properties.sv
cache_checker.sv
tb_cache.sv

//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - files:
      - cache_pkg.sv
      - lookup_if.sv
      - plru_tree.sv
      - tag_store.sv
      - line_store.sv
      - cache_ctrl.sv
      - cache_top.sv
  - target: test
    files:
      - cache_properties.sv
      - cache_checker.sv
      - tb_cache.sv
